/* Bender.yml */
package:
  name: ppu_bg

sources:
  - rtl/ppu_pkg.sv
  - rtl/lcd_regs.sv
  - rtl/line_timer.sv
  - rtl/bg_fetcher.sv
  - rtl/pixel_shifter.sv
  - rtl/ppu_top.sv
  - target: simulation
    files:
      - sim/ppu_checker.sv
      - sim/ppu_tb.sv

/* compile.f */
rtl/ppu_pkg.sv
rtl/lcd_regs.sv
rtl/line_timer.sv
rtl/bg_fetcher.sv
rtl/pixel_shifter.sv
rtl/ppu_top.sv
sim/ppu_checker.sv
sim/ppu_tb.sv

/* rtl/bg_fetcher.sv */
// six cycles per tile over a one-cycle-latency memory; a row left untaken at line_done is dropped
`timescale 1ns/1ps

module bg_fetcher
    import ppu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  lcd_ctrl_t   ctrl,
    input  logic [7:0]  ly,
    input  logic        line_start,
    input  logic        line_done,
    output logic        vram_rd,
    output logic [15:0] vram_addr,
    input  logic [7:0]  vram_data,
    output tile_row_t   row,
    output logic        row_valid,
    input  logic        row_ready
);

    logic        active;
    logic [2:0]  step;       // 0..5 within one tile
    logic [4:0]  col;        // map column, wraps at 32
    logic [7:0]  tile_num;
    logic [7:0]  bg_y;
    logic [15:0] map_addr;
    logic [15:0] tile_base;
    logic [15:0] tile_off;
    logic [15:0] tile_addr;
    logic [7:0]  plane_byte;
    logic        fetching;

    assign bg_y     = ly + ctrl.scy; // wraps mod 256
    assign map_addr = (ctrl.bg_map_hi ? map_base_hi : map_base_lo)
                    + {6'b0, bg_y[7:3], col};

    // signed mode sign-extends the index around 9000h
    assign tile_base = ctrl.tile_unsigned ? tile_base_unsigned : tile_base_signed;
    assign tile_off  = ctrl.tile_unsigned ? {4'b0, tile_num, 4'b0}
                                          : {{4{tile_num[7]}}, tile_num, 4'b0};
    assign tile_addr = tile_base + tile_off + {12'b0, bg_y[2:0], 1'b0};

    assign plane_byte = ctrl.bg_on ? vram_data : 8'h00; // same timing with bg off
    assign fetching   = active && ctrl.lcd_on && !row_valid;

    // even steps issue, odd steps capture
    assign vram_rd = fetching && !step[0];

    always_comb begin
        case (step)
            3'd0:    vram_addr = map_addr;
            3'd2:    vram_addr = tile_addr;
            default: vram_addr = tile_addr + 16'd1; // plane high
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            step      <= 3'd0;
            col       <= 5'd0;
            row_valid <= 1'b0;
        end else if (line_start) begin
            active    <= 1'b1;
            step      <= 3'd0;
            col       <= ctrl.scx[7:3];
            row_valid <= 1'b0;
        end else if (line_done || !ctrl.lcd_on) begin
            active    <= 1'b0;
            row_valid <= 1'b0;
        end else if (active) begin
            if (row_valid) begin
                if (row_ready) begin
                    row_valid <= 1'b0; // next tile starts at step 0
                end
            end else begin
                step <= (step == 3'd5) ? 3'd0 : step + 3'd1;
                if (step == 3'd0) begin
                    col <= col + 5'd1;
                end
                if (step == 3'd5) begin
                    row_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetching) begin
            case (step)
                3'd1:    tile_num     <= vram_data;
                3'd3:    row.plane_lo <= plane_byte;
                3'd5:    row.plane_hi <= plane_byte;
                default: ;
            endcase
        end
    end

endmodule

/* rtl/lcd_regs.sv */
// zero-wait APB register file; LY and STAT bits 2..0 are read-only, unmapped offsets read FFh
`timescale 1ns/1ps

module lcd_regs
    import ppu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    input  ppu_mode_t  mode,
    input  logic [7:0] ly,
    output lcd_ctrl_t  ctrl,
    output logic       irq_vblank,
    output logic       irq_stat
);

    logic [7:0] lcdc;
    logic [3:0] stat_en;  // STAT bits 6..3
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    logic [7:0] bgp;
    logic       wr_en;
    logic       lyc_eq;
    logic [7:0] stat;
    logic [7:0] rd_data;

    assign wr_en  = apb_req.psel & apb_req.penable & apb_req.pwrite; // access phase only
    assign lyc_eq = (lyc == ly);
    assign stat   = {1'b1, stat_en, lyc_eq, mode}; // bit 7 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            lcdc    <= 8'h00;
            stat_en <= 4'h0;
            scy     <= 8'h00;
            scx     <= 8'h00;
            lyc     <= 8'h00;
            bgp     <= 8'hE4; // identity shades
        end else if (wr_en) begin
            case (apb_req.paddr)
                reg_lcdc: lcdc    <= apb_req.pwdata;
                reg_stat: stat_en <= apb_req.pwdata[6:3];
                reg_scy:  scy     <= apb_req.pwdata;
                reg_scx:  scx     <= apb_req.pwdata;
                reg_lyc:  lyc     <= apb_req.pwdata;
                reg_bgp:  bgp     <= apb_req.pwdata;
                default: ;        // LY and unmapped offsets
            endcase
        end
    end

    always_comb begin
        case (apb_req.paddr)
            reg_lcdc: rd_data = lcdc;
            reg_stat: rd_data = stat;
            reg_scy:  rd_data = scy;
            reg_scx:  rd_data = scx;
            reg_ly:   rd_data = ly;  // live line counter
            reg_lyc:  rd_data = lyc;
            reg_bgp:  rd_data = bgp;
            default:  rd_data = 8'hFF;
        endcase
    end

    assign apb_rsp.prdata = rd_data;
    assign apb_rsp.pready = 1'b1; // no wait states

    assign ctrl.lcd_on        = lcdc[7];
    assign ctrl.bg_map_hi     = lcdc[3];
    assign ctrl.tile_unsigned = lcdc[4];
    assign ctrl.bg_on         = lcdc[0];
    assign ctrl.scx           = scx;
    assign ctrl.scy           = scy;
    assign ctrl.bgp           = bgp;

    assign irq_vblank = (mode == v_blank);

    // enabled STAT sources, level sensitive
    assign irq_stat = (lyc_eq && stat_en[3])
                   || ((mode == h_blank) && stat_en[0])
                   || ((mode == v_blank) && stat_en[1])
                   || ((mode == scan) && stat_en[2]);

endmodule

/* rtl/line_timer.sv */
// one dot per clock; draw must end via line_done before the last dot, TOTAL_LINES must fit 8 bits
`timescale 1ns/1ps

module line_timer
    import ppu_pkg::*;
#(
    parameter int LINE_DOTS     = 456,
    parameter int SCAN_DOTS     = 80,
    parameter int VISIBLE_LINES = 144,
    parameter int TOTAL_LINES   = 154
) (
    input  logic       clk,
    input  logic       rst,
    input  lcd_ctrl_t  ctrl,
    input  logic       line_done,
    output ppu_mode_t  mode,
    output logic [7:0] ly,
    output logic       line_start
);

    localparam int DOT_W = $clog2(LINE_DOTS);

    logic [DOT_W-1:0] dot;
    logic             line_end;
    logic [7:0]       ly_next;

    assign line_end = (dot == DOT_W'(LINE_DOTS - 1));
    assign ly_next  = (ly == 8'(TOTAL_LINES - 1)) ? 8'd0 : ly + 8'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            dot        <= '0;
            ly         <= 8'd0;
            mode       <= scan;
            line_start <= 1'b0;
        end else if (!ctrl.lcd_on) begin
            dot        <= '0; // idle, shown as h_blank
            ly         <= 8'd0;
            mode       <= h_blank;
            line_start <= 1'b0;
        end else begin
            line_start <= 1'b0;
            dot        <= dot + 1'b1;
            if (line_end) begin
                dot  <= '0;
                ly   <= ly_next;
                mode <= (ly_next < 8'(VISIBLE_LINES)) ? scan : v_blank;
            end else begin
                case (mode)
                    scan: begin
                        if (dot == DOT_W'(SCAN_DOTS - 1)) begin
                            mode       <= draw;
                            line_start <= 1'b1; // first draw cycle
                        end
                    end
                    draw: begin
                        if (line_done) begin
                            mode <= h_blank;
                        end
                    end
                    h_blank: begin
                        // dot 0 here only follows LCD off, so restart line 0
                        if (dot == '0) begin
                            mode <= scan;
                            dot  <= '0;
                        end
                    end
                    default: ;  // v_blank waits for line end
                endcase
            end
        end
    end

endmodule

/* rtl/pixel_shifter.sv */
// one tile row at a time; fine scroll drops SCX mod 8 leading pixels, line ends after 160 pixels
`timescale 1ns/1ps

module pixel_shifter
    import ppu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  lcd_ctrl_t ctrl,
    input  logic      line_start,
    input  tile_row_t row,
    input  logic      row_valid,
    output logic      row_ready,
    output logic [1:0] px,
    output logic      px_valid,
    output logic      line_done
);

    logic       active;
    logic [3:0] left;      // pixels still held
    logic [2:0] drop;      // scroll pixels still to discard
    logic [7:0] px_cnt;
    logic [7:0] sh_lo;
    logic [7:0] sh_hi;
    logic [1:0] color_idx;
    logic       shift;
    logic       take;
    logic       last_px;

    assign color_idx = {sh_hi[7], sh_lo[7]};
    assign px        = ctrl.bgp[{color_idx, 1'b0} +: 2];
    assign shift     = active && (left != 4'd0);
    assign px_valid  = shift && (drop == 3'd0);
    assign row_ready = active && (left <= 4'd1); // reload as the last pixel leaves
    assign take      = row_ready && row_valid;
    assign last_px   = px_valid && (px_cnt == 8'(screen_width - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            left      <= 4'd0;
            drop      <= 3'd0;
            px_cnt    <= 8'd0;
            line_done <= 1'b0;
        end else begin
            line_done <= last_px;
            if (line_start) begin
                active <= 1'b1;
                left   <= 4'd0;
                drop   <= ctrl.scx[2:0];
                px_cnt <= 8'd0;
            end else if (last_px || !ctrl.lcd_on) begin
                active <= 1'b0;
                left   <= 4'd0;
            end else begin
                if (take) begin
                    left <= 4'd8;
                end else if (shift) begin
                    left <= left - 4'd1;
                end
                if (shift && (drop != 3'd0)) begin
                    drop <= drop - 3'd1;
                end
                if (px_valid) begin
                    px_cnt <= px_cnt + 8'd1;
                end
            end
        end
    end

    // MSB first, leftmost pixel in bit 7
    always_ff @(posedge clk) begin
        if (take) begin
            sh_lo <= row.plane_lo;
            sh_hi <= row.plane_hi;
        end else if (shift) begin
            sh_lo <= {sh_lo[6:0], 1'b0};
            sh_hi <= {sh_hi[6:0], 1'b0};
        end
    end

endmodule

/* rtl/ppu_pkg.sv */
// background-only PPU types; APB offsets are relative to FF40, video memory is 64 KB byte-addressed
package ppu_pkg;

    // encoding follows the two STAT mode bits
    typedef enum logic [1:0] {
        h_blank = 2'd0,
        v_blank = 2'd1,
        scan    = 2'd2,
        draw    = 2'd3
    } ppu_mode_t;

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        logic [3:0] paddr;    // offset from FF40
        logic [7:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [7:0] prdata;
        logic       pready;
    } apb_rsp_t;

    // register fields the pixel pipeline reads
    typedef struct packed {
        logic       lcd_on;        // LCDC bit 7
        logic       bg_map_hi;     // LCDC bit 3
        logic       tile_unsigned; // LCDC bit 4
        logic       bg_on;         // LCDC bit 0
        logic [7:0] scx;
        logic [7:0] scy;
        logic [7:0] bgp;
    } lcd_ctrl_t;

    typedef struct packed {
        logic [7:0] plane_lo;
        logic [7:0] plane_hi;
    } tile_row_t;

    localparam logic [3:0] reg_lcdc = 4'h0;
    localparam logic [3:0] reg_stat = 4'h1;
    localparam logic [3:0] reg_scy  = 4'h2;
    localparam logic [3:0] reg_scx  = 4'h3;
    localparam logic [3:0] reg_ly   = 4'h4;
    localparam logic [3:0] reg_lyc  = 4'h5;
    localparam logic [3:0] reg_bgp  = 4'h7;

    localparam logic [15:0] map_base_lo        = 16'h9800;
    localparam logic [15:0] map_base_hi        = 16'h9C00;
    localparam logic [15:0] tile_base_unsigned = 16'h8000;
    localparam logic [15:0] tile_base_signed   = 16'h9000; // tile 0 sits mid-window

    localparam int screen_width = 160;

endpackage

/* rtl/ppu_top.sv */
// background path only, no sprites or window; video memory must answer exactly one cycle after vram_rd
`timescale 1ns/1ps

module ppu_top
    import ppu_pkg::*;
#(
    parameter int LINE_DOTS     = 456,
    parameter int SCAN_DOTS     = 80,
    parameter int VISIBLE_LINES = 144,
    parameter int TOTAL_LINES   = 154
) (
    input  logic        clk,
    input  logic        rst,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    output logic        vram_rd,
    output logic [15:0] vram_addr,
    input  logic [7:0]  vram_data,
    output logic [1:0]  px,
    output logic        px_valid,
    output logic        irq_vblank,
    output logic        irq_stat
);

    lcd_ctrl_t  ctrl;
    ppu_mode_t  mode;
    logic [7:0] ly;
    logic       line_start;
    logic       line_done;
    tile_row_t  row;
    logic       row_valid;
    logic       row_ready;

    lcd_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .mode       (mode),
        .ly         (ly),
        .ctrl       (ctrl),
        .irq_vblank (irq_vblank),
        .irq_stat   (irq_stat)
    );

    line_timer #(
        .LINE_DOTS     (LINE_DOTS),
        .SCAN_DOTS     (SCAN_DOTS),
        .VISIBLE_LINES (VISIBLE_LINES),
        .TOTAL_LINES   (TOTAL_LINES)
    ) u_timer (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .line_done  (line_done),
        .mode       (mode),
        .ly         (ly),
        .line_start (line_start)
    );

    bg_fetcher u_fetch (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .ly         (ly),
        .line_start (line_start),
        .line_done  (line_done),
        .vram_rd    (vram_rd),
        .vram_addr  (vram_addr),
        .vram_data  (vram_data),
        .row        (row),
        .row_valid  (row_valid),
        .row_ready  (row_ready)
    );

    pixel_shifter u_shift (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .line_start (line_start),
        .row        (row),
        .row_valid  (row_valid),
        .row_ready  (row_ready),
        .px         (px),
        .px_valid   (px_valid),
        .line_done  (line_done)
    );

endmodule

/* sim/ppu_checker.sv */
// bound into every ppu_top; rules are not checked while rst is high
`timescale 1ns/1ps

module ppu_checker
    import ppu_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input ppu_mode_t mode,
    input logic      px_valid,
    input logic      irq_vblank,
    input apb_rsp_t  apb_rsp,
    input logic      vram_rd
);

    int fails = 0;

    px_in_draw: assert property (@(posedge clk) disable iff (rst) px_valid |-> mode == draw)
        else begin fails++; $error("px_valid outside draw mode"); end

    vblank_irq: assert property (@(posedge clk) disable iff (rst)
                                 irq_vblank == (mode == v_blank))
        else begin fails++; $error("irq_vblank differs from v_blank mode"); end

    ready_high: assert property (@(posedge clk) disable iff (rst) apb_rsp.pready)
        else begin fails++; $error("pready dropped low"); end

    // no fetching between frames
    quiet_vblank: assert property (@(posedge clk) disable iff (rst)
                                   vram_rd |-> mode != v_blank)
        else begin fails++; $error("video memory read during v_blank"); end

endmodule

bind ppu_top ppu_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .mode       (mode),
    .px_valid   (px_valid),
    .irq_vblank (irq_vblank),
    .apb_rsp    (apb_rsp),
    .vram_rd    (vram_rd)
);

/* sim/ppu_tb.sv */
// reads sim/ppu_tests.txt relative to the run directory; frame checks assume 16 visible of 20 lines
`timescale 1ns/1ps

module ppu_tb
    import ppu_pkg::*;
;

    localparam int DOTS  = 456;
    localparam int VIS   = 16;
    localparam int TOTAL = 20;

    logic       clk = 1'b0;
    logic       rst;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic       vram_rd;
    logic [15:0] vram_addr;
    logic [7:0] vram_data = 8'h00;
    logic [1:0] px;
    logic       px_valid;
    logic       irq_vblank;
    logic       irq_stat;

    logic [7:0] vram [0:65535];
    logic [7:0] sh_lcdc;  // testbench copy of the written registers
    logic [7:0] sh_scx;
    logic [7:0] sh_scy;
    logic [7:0] sh_lyc;
    logic [7:0] sh_bgp;
    logic       sh_stat6;
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    int         limit  = 1000000; // replaced once the test file is counted
    int         seed   = 20;

    ppu_top #(.VISIBLE_LINES(VIS), .TOTAL_LINES(TOTAL)) dut (
        .clk        (clk),
        .rst        (rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .vram_rd    (vram_rd),
        .vram_addr  (vram_addr),
        .vram_data  (vram_data),
        .px         (px),
        .px_valid   (px_valid),
        .irq_vblank (irq_vblank),
        .irq_stat   (irq_stat)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (vram_rd) begin
            vram_data <= vram[vram_addr]; // one cycle latency
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic apb_setup(input logic wr, input logic [3:0] off, input logic [7:0] val);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= off;
        apb_req.pwdata  <= val;
        @(posedge clk);
        apb_req.penable <= 1'b1; // access phase
    endtask

    task automatic apb_write(input logic [3:0] off, input logic [7:0] val);
        apb_setup(1'b1, off, val);
        @(posedge clk);
        apb_req <= '0;
        case (off)
            4'h0: sh_lcdc  = val;
            4'h1: sh_stat6 = val[6];
            4'h2: sh_scy   = val;
            4'h3: sh_scx   = val;
            4'h5: sh_lyc   = val;
            4'h7: sh_bgp   = val;
            default: ;
        endcase
    endtask

    task automatic apb_read_check(input logic [3:0] off, input logic [7:0] exp);
        apb_setup(1'b0, off, 8'h00);
        @(negedge clk);
        checks++;
        if (apb_rsp.prdata !== exp) begin
            errors++;
            $display("mismatch at %0t: offset %h read %h, expected %h",
                     $time, off, apb_rsp.prdata, exp);
        end
        @(posedge clk);
        apb_req <= '0;
    endtask

    // background pixel at screen position from map, tile data and palette
    function automatic logic [1:0] ref_pixel(input int line, input int x);
        logic [7:0] bx;
        logic [7:0] by;
        logic [7:0] tnum;
        logic [7:0] lo;
        logic [7:0] hi;
        logic [1:0] idx;
        int         taddr;
        int         bit_pos;
        bx   = 8'(x) + sh_scx;
        by   = 8'(line) + sh_scy;
        tnum = vram[(sh_lcdc[3] ? 'h9C00 : 'h9800) + 32 * by[7:3] + bx[7:3]];
        if (sh_lcdc[4]) begin
            taddr = 'h8000 + 16 * tnum;
        end else begin
            taddr = 'h9000 + 16 * int'($signed(tnum)); // index -128..127 around 9000h
        end
        taddr   = taddr + 2 * by[2:0];
        lo      = vram[taddr];
        hi      = vram[taddr + 1];
        bit_pos = 7 - bx[2:0];
        idx     = {hi[bit_pos], lo[bit_pos]};
        if (!sh_lcdc[0]) begin
            idx = 2'd0;
        end
        return sh_bgp[2 * idx +: 2];
    endfunction

    task automatic run_frame();
        int         npx;
        int         line;
        logic [1:0] exp_px;
        logic       exp_stat;
        npx = 0;
        @(negedge clk);
        while (!irq_vblank) @(negedge clk);
        while (irq_vblank) @(negedge clk); // line count starts here
        while (!irq_vblank) begin
            if (px_valid) begin
                line     = npx / 160;
                exp_px   = ref_pixel(line, npx % 160);
                exp_stat = sh_stat6 && (line == sh_lyc);
                checks   = checks + 2;
                if (px !== exp_px) begin
                    errors++;
                    $display("mismatch at %0t: line %0d x %0d pixel %0d, expected %0d",
                             $time, line, npx % 160, px, exp_px);
                end
                if (irq_stat !== exp_stat) begin
                    errors++;
                    $display("mismatch at %0t: line %0d irq_stat %b, expected %b",
                             $time, line, irq_stat, exp_stat);
                end
                npx++;
            end
            @(negedge clk);
        end
        checks++;
        if (npx != VIS * 160) begin
            errors++;
            $display("mismatch at %0t: %0d pixels before vblank, expected %0d",
                     $time, npx, VIS * 160);
        end
    endtask

    task automatic run_dark_frame();
        repeat (DOTS * TOTAL) begin
            @(negedge clk);
            checks++;
            if (px_valid || vram_rd) begin
                errors++;
                $display("mismatch at %0t: pixel or memory read with LCD off", $time);
            end
        end
    endtask

    initial begin : main
        int          fd;
        int          nf;
        int          code;
        int          r;
        string       line;
        byte         c;
        logic [15:0] a;
        logic [7:0]  d;
        rst      = 1'b1;
        apb_req  = '0;
        sh_lcdc  = 8'h00;
        sh_scx   = 8'h00;
        sh_scy   = 8'h00;
        sh_lyc   = 8'h00;
        sh_bgp   = 8'hE4;
        sh_stat6 = 1'b0;
        for (int i = 0; i < 65536; i++) begin
            r       = $random(seed);
            vram[i] = (i >= 'h8000 && i < 'hA000) ? r[7:0] : (i[15:8] ^ i[7:0]);
        end
        nf = 0;
        fd = $fopen("sim/ppu_tests.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.getc(0) == "F") nf++;
            end
            $fclose(fd);
        end
        limit = TOTAL * DOTS * (nf + 1) + 1000;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("sim/ppu_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the test file sim/ppu_tests.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%c %h %h", c, a, d);
                    if (c != "F" && code != 3) begin
                        errors++;
                        $display("malformed line in test file: %s", line);
                    end else begin
                        case (c)
                            "V": vram[a] = d;
                            "W": apb_write(a[3:0], d);
                            "R": apb_read_check(a[3:0], d);
                            "F": if (sh_lcdc[7]) run_frame(); else run_dark_frame();
                            default: begin
                                errors++;
                                $display("unknown command in test file: %s", line);
                            end
                        endcase
                    end
                end
            end
            $fclose(fd);
        end
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut.u_checker.fails);
        if (errors == 0 && dut.u_checker.fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sim/ppu_tests.txt */
# V addr byte = video memory load, W reg value = APB write, R reg expected = APB read
# F = run one frame and check it; reg is the offset from FF40, all numbers hex
V 9800 00
V 8000 F0
V 8001 CC
V 9C20 80
V 8806 AA
V 8807 0F
R 7 E4
W 5 03
W 1 FF
R 1 F8
W 4 55
R 4 00
W 2 A5
R 2 A5
W 3 3C
R 3 3C
W 7 1B
R 7 1B
R 6 FF
R F FF
W 1 40
W 2 00
W 3 00
W 7 E4
W 0 91
R 0 91
F
W 2 0B
W 3 05
W 0 89
F
W 0 88
F
W 0 91
W 3 ED
W 7 1B
F
W 0 00
F
R 4 00
R 1 C0
